// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = fetch_tb
FILELIST   = sources.f
OBJ_DIR    = obj_dir
PASS_MSG   = No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_consts.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int LINE_BYTES = `FETCH_LINE_BYTES;
    localparam int BUF_BYTES  = `FETCH_LINES * `FETCH_LINE_BYTES;
    localparam int MAX_CYCLES = 400;

    logic          clk;
    logic          arst_n;
    ibuf_fill_t    fill;
    decode_fb_t    dec;
    cf_redirect_t  cf;
    ibuf_line_u    idtr_packet;
    logic          packet_select;
    fetch_packet_t packet;
    bip_t          old_bip;
    bip_t          new_bip;

    // reference model of the buffer and pointer
    logic [7:0]              mem [BUF_BYTES];
    logic [`FETCH_LINES-1:0] mvalid;
    int                      mbip;
    logic                    mvq;
    integer                  seed;
    int                      cycles;

    fetch_unit UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .fill          (fill),
        .dec           (dec),
        .cf            (cf),
        .idtr_packet   (idtr_packet),
        .packet_select (packet_select),
        .packet        (packet),
        .old_bip       (old_bip),
        .new_bip       (new_bip)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // model and checks
    //////////////////////////////////////////////////////////////////////

    function automatic int calc_new_bip();
        return (mbip + int'(dec.length)) % BUF_BYTES;
    endfunction

    // needs the window line and the one after it, line 3 wrapping to 0
    function automatic logic window_ok();
        int line;
        line = calc_new_bip() / LINE_BYTES;
        return packet_select | (mvalid[line] & mvalid[(line + 1) % `FETCH_LINES]);
    endfunction

    // packet byte 0 lands in the top byte
    function automatic logic [127:0] window_data();
        logic [127:0] w;
        int           nb;
        nb = calc_new_bip();
        for (int k = 0; k < LINE_BYTES; k++) begin
            w[127 - 8*k -: 8] = mem[(nb + k) % BUF_BYTES];
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs();
        check_value("old_bip", old_bip, mbip);
        check_value("new_bip", new_bip, calc_new_bip());
        check_value("packet.valid", packet.valid, window_ok());
        if (window_ok()) begin
            if (packet_select) begin
                check_value("packet.data", packet.data.word, idtr_packet.word);
            end else begin
                check_value("packet.data", packet.data.word, window_data());
            end
        end
    endtask

    // check this cycle and then follow the clock edge in the model
    task automatic clock_cycle();
        int   tgt;
        logic nv;
        #2;
        compare_outputs();
        nv = window_ok();
        if (cf.is_init) begin
            tgt = cf.init_bip;
        end else if (cf.is_resteer) begin
            tgt = cf.wb_bip;
        end else if (cf.is_br_taken) begin
            tgt = cf.bp_bip;
        end else begin
            tgt = calc_new_bip();
        end
        @(posedge clk);
        if (!dec.stall && mvq) begin
            if (tgt / LINE_BYTES != mbip / LINE_BYTES) begin
                mvalid[mbip / LINE_BYTES] = 1'b0;
            end
            mbip = tgt;
        end
        if (!dec.stall) begin
            mvq = nv;
        end
        if (fill.en) begin
            mvalid[fill.idx] = 1'b1;
            for (int k = 0; k < LINE_BYTES; k++) begin
                mem[fill.idx * LINE_BYTES + k] = fill.data.bytes[k];
            end
        end
        @(negedge clk);
        fill.en        = 1'b0;
        cf.is_init     = 1'b0;
        cf.is_resteer  = 1'b0;
        cf.is_br_taken = 1'b0;
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        mvalid = '0;
        mbip   = 0;
        mvq    = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic fill_line(input int idx);
        ibuf_line_u line;
        for (int k = 0; k < LINE_BYTES; k++) begin
            line.bytes[k] = 8'($random(seed));
        end
        fill.en   = 1'b1;
        fill.idx  = 2'(idx);
        fill.data = line;
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_and_fill();
        dec = '0;
        fill_line(0);
        #2 check_value("packet.valid", packet.valid, 1'b0);
        clock_cycle();
        // line 1 still missing
        fill_line(1);
        #2 check_value("packet.valid", packet.valid, 1'b0);
        check_value("old_bip", old_bip, 6'd0);
        clock_cycle();
        #2 check_value("packet.valid", packet.valid, 1'b1);
        check_value("packet.data", packet.data.word, window_data());
        clock_cycle();
    endtask

    task automatic sequential_advance();
        int lens [6];
        lens = '{3, 5, 16, 7, 16, 7};
        fill_line(2);
        clock_cycle();
        fill_line(3);
        clock_cycle();
        for (int i = 0; i < 6; i++) begin
            dec.length = 8'(lens[i]);
            // line 0 was released at 24 and the wrap needs it back
            if (i == 4) begin
                fill_line(0);
            end
            clock_cycle();
        end
    endtask

    task automatic stall_hold();
        bip_t         held_bip;
        logic [127:0] held_data;
        dec.length = 8'd4;
        dec.stall  = 1'b1;
        held_bip   = 6'(mbip);
        held_data  = window_data();
        for (int i = 0; i < 3; i++) begin
            clock_cycle();
            if (i == 2) begin
                dec.stall = 1'b0;
            end
            #2 check_value("old_bip", old_bip, held_bip);
            check_value("packet.data", packet.data.word, held_data);
        end
        clock_cycle();
        #2 check_value("old_bip", old_bip, 6'((held_bip + 4) % BUF_BYTES));
    endtask

    task automatic redirect_priority();
        dec.length = 8'd0;
        fill_line(1);
        clock_cycle();
        fill_line(2);
        clock_cycle();
        cf = '{is_init: 1'b0, init_bip: 6'd0, is_resteer: 1'b0, wb_bip: 6'd0,
               is_br_taken: 1'b1, bp_bip: 6'd20};
        clock_cycle();
        #2 check_value("old_bip", old_bip, 6'd20);
        clock_cycle();
        cf = '{is_init: 1'b0, init_bip: 6'd0, is_resteer: 1'b1, wb_bip: 6'd25,
               is_br_taken: 1'b1, bp_bip: 6'd18};
        clock_cycle();
        #2 check_value("old_bip", old_bip, 6'd25);
        clock_cycle();
        cf = '{is_init: 1'b1, init_bip: 6'd17, is_resteer: 1'b1, wb_bip: 6'd28,
               is_br_taken: 1'b1, bp_bip: 6'd19};
        clock_cycle();
        #2 check_value("old_bip", old_bip, 6'd17);
        clock_cycle();
    endtask

    task automatic release_and_refill();
        fill_line(3);
        clock_cycle();
        // 17 to 33 leaves line 1
        dec.length = 8'd16;
        clock_cycle();
        // 33 to 0 needs line 1 again
        dec.length = 8'd31;
        clock_cycle();
        dec.length = 8'd0;
        fill_line(1);
        #2 check_value("packet.valid", packet.valid, 1'b0);
        clock_cycle();
        #2 check_value("packet.valid", packet.valid, 1'b1);
        check_value("packet.data", packet.data.word, window_data());
        clock_cycle();
    endtask

    task automatic descriptor_override();
        apply_reset();
        idtr_packet.word = {$random(seed), $random(seed), $random(seed), $random(seed)};
        packet_select    = 1'b1;
        #2 check_value("packet.valid", packet.valid, 1'b1);
        check_value("packet.data", packet.data.word, idtr_packet.word);
        clock_cycle();
        packet_select = 1'b0;
        clock_cycle();
    endtask

    initial begin
        seed          = 21;
        cycles        = 0;
        fill          = '0;
        dec           = '0;
        cf            = '0;
        idtr_packet   = '0;
        packet_select = 1'b0;
        apply_reset();
        reset_and_fill();
        sequential_advance();
        stall_hold();
        redirect_priority();
        release_and_refill();
        descriptor_override();
        $display("No errors");
        $finish;
    end

endmodule

// File: hdl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// instruction buffer geometry
`define FETCH_LINES      4
`define FETCH_LINE_BYTES 16

// byte pointer covers the whole 64-byte buffer
`define FETCH_BIP_W      6

// instruction length reported by decode
`define FETCH_LEN_W      8

`endif

// File: hdl/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

    // byte instruction pointer
    typedef logic [`FETCH_BIP_W-1:0] bip_t;

    // one buffer line, byte 0 sits in the top byte of the word
    typedef union packed {
        logic [8*`FETCH_LINE_BYTES-1:0]    word;
        logic [0:`FETCH_LINE_BYTES-1][7:0] bytes;
    } ibuf_line_u;

    typedef struct packed {
        logic                            en;
        logic [$clog2(`FETCH_LINES)-1:0] idx;
        ibuf_line_u                      data;
    } ibuf_fill_t;

    // redirect strobes, one cycle each
    typedef struct packed {
        logic is_init;
        bip_t init_bip;
        logic is_resteer;
        bip_t wb_bip;
        logic is_br_taken;
        bip_t bp_bip;
    } cf_redirect_t;

    typedef struct packed {
        logic [`FETCH_LEN_W-1:0] length;
        logic                    stall;
    } decode_fb_t;

    typedef struct packed {
        ibuf_line_u data;
        logic       valid;
    } fetch_packet_t;

endpackage

// File: hdl/fetch_redirect.sv
`timescale 1ns/10ps

module fetch_redirect import fetch_pkg::*; (
    input  cf_redirect_t cf,
    output logic         is_cf,
    output bip_t         cf_bip
);

    // any strobe forces a pointer load from the redirect path
    assign is_cf = cf.is_init | cf.is_resteer | cf.is_br_taken;

    // init beats resteer, resteer beats the predicted branch
    always_comb begin
        if (cf.is_init) begin
            cf_bip = cf.init_bip;
        end else if (cf.is_resteer) begin
            cf_bip = cf.wb_bip;
        end else if (cf.is_br_taken) begin
            cf_bip = cf.bp_bip;
        end else begin
            cf_bip = '0;
        end
    end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/10ps
`include "fetch_consts.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic                            clk,
    input  logic                            arst_n,

    // instruction buffer
    input  ibuf_line_u [`FETCH_LINES-1:0]   lines,
    input  logic [`FETCH_LINES-1:0]         line_valid,

    // decode, redirects, descriptor override
    input  decode_fb_t                      dec,
    input  cf_redirect_t                    cf,
    input  ibuf_line_u                      idtr_packet,
    input  logic                            packet_select,

    output fetch_packet_t                   packet,
    output bip_t                            old_bip,
    output bip_t                            new_bip,

    output logic                            release_en,
    output logic [$clog2(`FETCH_LINES)-1:0] release_idx
);

    localparam int LINE_W = $clog2(`FETCH_LINES);

    bip_t                    bip_q;
    bip_t                    load_bip;
    bip_t                    cf_bip;
    logic [`FETCH_LEN_W-1:0] bip_ext;
    logic                    is_cf;
    logic                    ld_bip;
    logic                    valid_q;
    logic                    window_valid;
    ibuf_line_u              window;

    //////////////////////////////////////////////////////////////////////
    // pointer update
    //////////////////////////////////////////////////////////////////////

    // length adder, result wraps at the buffer size
    assign bip_ext = {{(`FETCH_LEN_W - `FETCH_BIP_W){1'b0}}, bip_q};
    assign new_bip = bip_t'(bip_ext + dec.length);

    fetch_redirect u_redirect (
        .cf     (cf),
        .is_cf  (is_cf),
        .cf_bip (cf_bip)
    );

    assign load_bip = is_cf ? cf_bip : new_bip;

    // decode consumes the packet seen one cycle earlier
    assign ld_bip = !dec.stall && valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bip_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (!dec.stall) begin
                valid_q <= packet.valid;
            end
            if (ld_bip) begin
                bip_q <= load_bip;
            end
        end
    end

    // leaving a line frees the one under the old pointer
    assign release_idx = bip_q[`FETCH_BIP_W-1 -: LINE_W];
    assign release_en  = ld_bip && (load_bip[`FETCH_BIP_W-1 -: LINE_W] != release_idx);

    assign old_bip = bip_q;

    //////////////////////////////////////////////////////////////////////
    // packet
    //////////////////////////////////////////////////////////////////////

    line_window_check u_check (
        .curr_line    (new_bip[`FETCH_BIP_W-1 -: LINE_W]),
        .line_valid   (line_valid),
        .window_valid (window_valid)
    );

    ibuf_rotator u_rotator (
        .lines  (lines),
        .rot    (new_bip),
        .window (window)
    );

    assign packet.data  = packet_select ? idtr_packet : window;
    assign packet.valid = window_valid | packet_select;

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps
`include "fetch_consts.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,

    input  ibuf_fill_t    fill,
    input  decode_fb_t    dec,
    input  cf_redirect_t  cf,
    input  ibuf_line_u    idtr_packet,
    input  logic          packet_select,

    output fetch_packet_t packet,
    output bip_t          old_bip,
    output bip_t          new_bip
);

    ibuf_line_u [`FETCH_LINES-1:0]   lines;
    logic [`FETCH_LINES-1:0]         line_valid;
    logic                            release_en;
    logic [$clog2(`FETCH_LINES)-1:0] release_idx;

    ibuf_lines u_lines (
        .clk         (clk),
        .arst_n      (arst_n),
        .fill        (fill),
        .release_en  (release_en),
        .release_idx (release_idx),
        .lines       (lines),
        .line_valid  (line_valid)
    );

    fetch_stage u_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .lines         (lines),
        .line_valid    (line_valid),
        .dec           (dec),
        .cf            (cf),
        .idtr_packet   (idtr_packet),
        .packet_select (packet_select),
        .packet        (packet),
        .old_bip       (old_bip),
        .new_bip       (new_bip),
        .release_en    (release_en),
        .release_idx   (release_idx)
    );

endmodule

// File: hdl/ibuf_lines.sv
`timescale 1ns/10ps
`include "fetch_consts.svh"

module ibuf_lines import fetch_pkg::*; (
    input  logic                            clk,
    input  logic                            arst_n,

    input  ibuf_fill_t                      fill,

    input  logic                            release_en,
    input  logic [$clog2(`FETCH_LINES)-1:0] release_idx,

    output ibuf_line_u [`FETCH_LINES-1:0]   lines,
    output logic [`FETCH_LINES-1:0]         line_valid
);

    ibuf_line_u [`FETCH_LINES-1:0] line_q;
    logic [`FETCH_LINES-1:0]       valid_q;
    logic [`FETCH_LINES-1:0]       valid_d;

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    // write strobe from the fill engine
    always_ff @(posedge clk) begin
        if (fill.en) begin
            line_q[fill.idx] <= fill.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////////////////////////

    // release first, then fill
    // a fill and a release on the same line leave it valid
    always_comb begin
        valid_d = valid_q;
        if (release_en) begin
            valid_d[release_idx] = 1'b0;
        end
        if (fill.en) begin
            valid_d[fill.idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    assign lines      = line_q;
    assign line_valid = valid_q;

endmodule

// File: hdl/ibuf_rotator.sv
`timescale 1ns/10ps
`include "fetch_consts.svh"

module ibuf_rotator import fetch_pkg::*; (
    input  ibuf_line_u [`FETCH_LINES-1:0] lines,
    input  bip_t                          rot,
    output ibuf_line_u                    window
);

    localparam int RING_BYTES = `FETCH_LINES * `FETCH_LINE_BYTES;
    localparam int STAGES     = $clog2(RING_BYTES);

    logic [RING_BYTES-1:0][7:0] ring;
    logic [RING_BYTES-1:0][7:0] stage [STAGES+1];

    //////////////////////////////////////////////////////////////////////
    // ring assembly
    //////////////////////////////////////////////////////////////////////

    // ring[n] is buffer byte n
    // line bytes are held top byte first so this flips the byte order
    always_comb begin
        for (int n = 0; n < RING_BYTES; n++) begin
            ring[n] = lines[n / `FETCH_LINE_BYTES].bytes[n % `FETCH_LINE_BYTES];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // log shifter
    //////////////////////////////////////////////////////////////////////

    // stage s moves the ring down by 2**s bytes when rot[s] is set
    always_comb begin
        stage[0] = ring;
        for (int s = 0; s < STAGES; s++) begin
            for (int n = 0; n < RING_BYTES; n++) begin
                if (rot[s]) begin
                    stage[s+1][n] = stage[s][(n + (1 << s)) % RING_BYTES];
                end else begin
                    stage[s+1][n] = stage[s][n];
                end
            end
        end
    end

    // packet byte k is ring byte rot + k
    always_comb begin
        for (int k = 0; k < `FETCH_LINE_BYTES; k++) begin
            window.bytes[k] = stage[STAGES][k];
        end
    end

endmodule

// File: hdl/line_window_check.sv
`timescale 1ns/10ps
`include "fetch_consts.svh"

module line_window_check (
    input  logic [$clog2(`FETCH_LINES)-1:0] curr_line,
    input  logic [`FETCH_LINES-1:0]         line_valid,
    output logic                            window_valid
);

    logic [`FETCH_LINES-1:0] line_sel;
    logic [`FETCH_LINES-1:0] pair_ok;

    // one-hot of the line under the window start
    always_comb begin
        line_sel = '0;
        line_sel[curr_line] = 1'b1;
    end

    // a 16-byte window always touches this line and the next one
    for (genvar i = 0; i < `FETCH_LINES; i++) begin : g_pair
        assign pair_ok[i] = line_sel[i] & line_valid[i]
                          & line_valid[(i + 1) % `FETCH_LINES];
    end

    assign window_valid = |pair_ok;

endmodule

// File: sources.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_redirect.sv
hdl/line_window_check.sv
hdl/ibuf_rotator.sv
hdl/ibuf_lines.sv
hdl/fetch_stage.sv
hdl/fetch_unit.sv
dv/fetch_tb.sv
